/* verilog/exe_settings.svh */
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// datapath and register file
`define EXE_DATA_W      32
`define EXE_REG_ADDR_W  5

// instruction immediate
`define EXE_IMM_W       16

// data memory request fields
`define EXE_STRB_W      4
`define EXE_SIZE_W      3

// exception code field
`define EXE_EXCODE_W    5

// return address is pc + 8 past the delay slot
`define EXE_LINK_OFFSET 8

`endif

/* verilog/exe_pkg.sv */
`include "exe_settings.svh"

package exe_pkg;

    // alu and hi/lo operations
    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_mult,
        alu_multu,
        alu_mthi,
        alu_mtlo,
        alu_mfhi,
        alu_mflo
    } alu_op_t;

    // data memory access
    typedef enum logic [3:0] {
        mem_none,
        mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu,
        mem_sw, mem_sh, mem_sb, mem_swl, mem_swr
    } mem_op_t;

    // sa is imm[10:6] zero-extended
    typedef enum logic [1:0] {
        src1_rs,
        src1_pc,
        src1_sa
    } src1_sel_t;

    typedef enum logic [1:0] {
        src2_rt,
        src2_simm,
        src2_zimm,
        src2_link
    } src2_sel_t;

    typedef enum logic [`EXE_EXCODE_W-1:0] {
        exc_none = 0,
        exc_adel = 4,
        exc_ades = 5,
        exc_ov   = 12
    } exc_code_t;

endpackage

/* verilog/exe_op_if.sv */
`include "exe_settings.svh"

interface exe_op_if
    import exe_pkg::*;
();
    // held instruction
    logic                    valid;
    alu_op_t                 alu_op;
    src1_sel_t               src1_sel;
    src2_sel_t               src2_sel;
    logic [`EXE_IMM_W-1:0]   imm;
    logic [`EXE_DATA_W-1:0]  rs_value;
    logic [`EXE_DATA_W-1:0]  rt_value;
    logic [`EXE_DATA_W-1:0]  pc;
    mem_op_t                 mem_op;
    logic                    commit;
    logic                    store_ok;

    // datapath results
    logic [`EXE_DATA_W-1:0]  src1;
    logic [`EXE_DATA_W-1:0]  src2;
    logic [`EXE_DATA_W-1:0]  alu_result;
    logic                    overflow;
    logic [`EXE_DATA_W-1:0]  hi_value;
    logic [`EXE_DATA_W-1:0]  lo_value;

    modport ctrl (
        output valid, alu_op, src1_sel, src2_sel, imm, rs_value, rt_value, pc, mem_op,
        output commit, store_ok,
        input  alu_result, overflow
    );

    modport alu (
        input  alu_op, src1_sel, src2_sel, imm, rs_value, rt_value, pc, hi_value, lo_value,
        output src1, src2, alu_result, overflow
    );

    modport hilo (
        input  alu_op, src1, src2, commit,
        output hi_value, lo_value
    );

    modport store (
        input  mem_op, rt_value, alu_result, store_ok
    );

endinterface

/* verilog/exe_control.sv */
`include "exe_settings.svh"

module exe_control
    import exe_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  alu_op_t                    in_alu_op,
    input  src1_sel_t                  in_src1_sel,
    input  src2_sel_t                  in_src2_sel,
    input  mem_op_t                    in_mem_op,
    input  logic [`EXE_IMM_W-1:0]      in_imm,
    input  logic [`EXE_DATA_W-1:0]     in_rs_value,
    input  logic [`EXE_DATA_W-1:0]     in_rt_value,
    input  logic [`EXE_DATA_W-1:0]     in_pc,
    input  logic [`EXE_REG_ADDR_W-1:0] in_dest,
    input  logic                       in_gr_we,
    input  logic                       in_ov_check,
    input  logic                       out_ready,
    output logic                       out_valid,
    output logic [`EXE_REG_ADDR_W-1:0] out_dest,
    output logic                       out_gr_we,
    output mem_op_t                    out_mem_op,
    output logic                       out_ex,
    output exc_code_t                  out_excode,
    output logic                       mem_req,
    output logic [`EXE_DATA_W-1:0]     mem_addr,
    input  logic                       mem_addr_ok,
    exe_op_if.ctrl                     op
);

    logic                       accepted;
    logic [`EXE_REG_ADDR_W-1:0] dest;
    logic                       gr_we;
    logic                       ov_check;
    logic                       live;
    logic                       has_mem_op;
    logic                       ready_go;
    logic [1:0]                 addr_lo;
    logic                       ov_hit;
    logic                       adel_hit;
    logic                       ades_hit;

    // stage register
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            op.valid <= 1'b0;
        end else if (in_ready) begin
            op.valid <= in_valid;
        end
        if (in_valid && in_ready) begin
            op.alu_op   <= in_alu_op;
            op.src1_sel <= in_src1_sel;
            op.src2_sel <= in_src2_sel;
            op.mem_op   <= in_mem_op;
            op.imm      <= in_imm;
            op.rs_value <= in_rs_value;
            op.rt_value <= in_rt_value;
            op.pc       <= in_pc;
            dest        <= in_dest;
            gr_we       <= in_gr_we;
            ov_check    <= in_ov_check;
        end
    end

    // set once the address is taken and held until the instruction leaves
    always_ff @(posedge clk) begin
        if (reset || flush || (out_valid && out_ready)) begin
            accepted <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            accepted <= 1'b1;
        end
    end

    assign addr_lo  = op.alu_result[1:0];
    assign ov_hit   = ov_check && op.overflow;
    assign adel_hit = (op.mem_op == mem_lw && addr_lo != 2'b00) ||
                      (op.mem_op inside {mem_lh, mem_lhu} && addr_lo[0]);
    assign ades_hit = (op.mem_op == mem_sw && addr_lo != 2'b00) ||
                      (op.mem_op == mem_sh && addr_lo[0]);

    assign out_ex = ov_hit || adel_hit || ades_hit;

    always_comb begin
        if (ov_hit) begin
            out_excode = exc_ov;
        end else if (adel_hit) begin
            out_excode = exc_adel;
        end else if (ades_hit) begin
            out_excode = exc_ades;
        end else begin
            out_excode = exc_none;
        end
    end

    // a flushed instruction neither requests nor leaves
    assign live       = op.valid && !flush;
    assign has_mem_op = (op.mem_op != mem_none);
    assign ready_go   = !has_mem_op || out_ex || accepted || mem_addr_ok;
    assign out_valid  = live && ready_go;
    assign in_ready   = !op.valid || (ready_go && out_ready);

    assign mem_req  = live && has_mem_op && !out_ex && !accepted;
    assign mem_addr = op.alu_result;

    assign op.commit   = out_valid && out_ready && !out_ex;
    assign op.store_ok = mem_req && (op.mem_op inside {mem_sw, mem_sh, mem_sb, mem_swl, mem_swr});

    assign out_dest   = dest;
    assign out_gr_we  = gr_we;
    assign out_mem_op = op.mem_op;

endmodule

/* verilog/exe_alu.sv */
`include "exe_settings.svh"

module exe_alu
    import exe_pkg::*;
(
    exe_op_if.alu                  op,
    output logic [`EXE_DATA_W-1:0] out_result
);

    logic                   is_sub;
    logic [`EXE_DATA_W-1:0] adder_b;
    logic [`EXE_DATA_W-1:0] adder_sum;
    logic [4:0]             shamt;

    always_comb begin
        case (op.src1_sel)
            src1_pc: op.src1 = op.pc;
            src1_sa: op.src1 = {{(`EXE_DATA_W - 5){1'b0}}, op.imm[10:6]};
            default: op.src1 = op.rs_value;
        endcase
    end

    always_comb begin
        case (op.src2_sel)
            src2_simm: begin
                op.src2 = {{(`EXE_DATA_W - `EXE_IMM_W){op.imm[`EXE_IMM_W-1]}}, op.imm};
            end
            src2_zimm: begin
                op.src2 = {{(`EXE_DATA_W - `EXE_IMM_W){1'b0}}, op.imm};
            end
            src2_link: begin
                op.src2 = `EXE_DATA_W'(`EXE_LINK_OFFSET);
            end
            default: begin
                op.src2 = op.rt_value;
            end
        endcase
    end

    // shared adder, sub as a + ~b + 1
    assign is_sub    = (op.alu_op == alu_sub);
    assign adder_b   = is_sub ? ~op.src2 : op.src2;
    assign adder_sum = op.src1 + adder_b + `EXE_DATA_W'(is_sub);

    // operands agree in sign but the sum does not
    assign op.overflow = (op.alu_op inside {alu_add, alu_sub}) &&
                         (op.src1[`EXE_DATA_W-1] == adder_b[`EXE_DATA_W-1]) &&
                         (adder_sum[`EXE_DATA_W-1] != op.src1[`EXE_DATA_W-1]);

    assign shamt = op.src1[4:0];

    always_comb begin
        case (op.alu_op)
            alu_add, alu_sub: begin
                op.alu_result = adder_sum;
            end
            alu_slt: begin
                op.alu_result = `EXE_DATA_W'($signed(op.src1) < $signed(op.src2));
            end
            alu_sltu: begin
                op.alu_result = `EXE_DATA_W'(op.src1 < op.src2);
            end
            alu_and: op.alu_result = op.src1 & op.src2;
            alu_or:  op.alu_result = op.src1 | op.src2;
            alu_xor: op.alu_result = op.src1 ^ op.src2;
            alu_nor: op.alu_result = ~(op.src1 | op.src2);
            alu_sll: op.alu_result = op.src2 << shamt;
            alu_srl: op.alu_result = op.src2 >> shamt;
            alu_sra: begin
                op.alu_result = $unsigned($signed(op.src2) >>> shamt);
            end
            alu_lui: begin
                op.alu_result = {op.imm, {(`EXE_DATA_W - `EXE_IMM_W){1'b0}}};
            end
            // mult operands and move sources go out as rs
            alu_mult, alu_multu, alu_mthi, alu_mtlo: begin
                op.alu_result = op.src1;
            end
            default: begin
                op.alu_result = '0;
            end
        endcase
    end

    always_comb begin
        case (op.alu_op)
            alu_mfhi: out_result = op.hi_value;
            alu_mflo: out_result = op.lo_value;
            default:  out_result = op.alu_result;
        endcase
    end

endmodule

/* verilog/exe_hilo.sv */
`include "exe_settings.svh"

module exe_hilo
    import exe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    exe_op_if.hilo op
);

    logic                                signed_mul;
    logic signed [2*`EXE_DATA_W+1:0]     product_full;
    logic        [2*`EXE_DATA_W-1:0]     product;

    // one multiplier, operands widened by one sign or zero bit
    assign signed_mul   = (op.alu_op == alu_mult);
    assign product_full = $signed({signed_mul && op.src1[`EXE_DATA_W-1], op.src1}) *
                          $signed({signed_mul && op.src2[`EXE_DATA_W-1], op.src2});
    assign product      = product_full[2*`EXE_DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            op.hi_value <= '0;
            op.lo_value <= '0;
        end else if (op.commit) begin
            case (op.alu_op)
                alu_mult, alu_multu: begin
                    op.hi_value <= product[2*`EXE_DATA_W-1:`EXE_DATA_W];
                    op.lo_value <= product[`EXE_DATA_W-1:0];
                end
                alu_mthi: begin
                    op.hi_value <= op.src1;
                end
                alu_mtlo: begin
                    op.lo_value <= op.src1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* verilog/exe_store_format.sv */
`include "exe_settings.svh"

module exe_store_format
    import exe_pkg::*;
(
    exe_op_if.store                op,
    output logic                   mem_wr,
    output logic [`EXE_SIZE_W-1:0] mem_size,
    output logic [`EXE_STRB_W-1:0] mem_wstrb,
    output logic [`EXE_DATA_W-1:0] mem_wdata
);

    logic [1:0]             offset;
    logic [`EXE_STRB_W-1:0] strb;

    assign offset = op.alu_result[1:0];

    // lane placement
    always_comb begin
        case (op.mem_op)
            mem_sb:  mem_wdata = {4{op.rt_value[7:0]}};
            mem_sh:  mem_wdata = {2{op.rt_value[15:0]}};
            // swl keeps the high bytes, 24 bits right at offset 0
            mem_swl: mem_wdata = op.rt_value >> {~offset, 3'b000};
            mem_swr: mem_wdata = op.rt_value << {offset, 3'b000};
            default: mem_wdata = op.rt_value;
        endcase
    end

    always_comb begin
        case (op.mem_op)
            mem_sw:  strb = 4'hf;
            mem_sb:  strb = 4'h1 << offset;
            mem_sh:  strb = offset[1] ? 4'hc : 4'h3;
            // 1, 3, 7, f
            mem_swl: strb = ~(4'he << offset);
            // f, e, c, 8
            mem_swr: strb = 4'hf << offset;
            default: strb = 4'h0;
        endcase
    end

    // no strobes unless a live store request is out
    assign mem_wstrb = op.store_ok ? strb : '0;

    always_comb begin
        case (op.mem_op)
            mem_lb, mem_lbu, mem_sb: begin
                mem_size = `EXE_SIZE_W'(0);
            end
            mem_lh, mem_lhu, mem_sh: begin
                mem_size = `EXE_SIZE_W'(1);
            end
            mem_lw, mem_sw, mem_swl, mem_swr: begin
                mem_size = `EXE_SIZE_W'(2);
            end
            default: begin
                mem_size = `EXE_SIZE_W'(0);
            end
        endcase
    end

    assign mem_wr = (op.mem_op inside {mem_sw, mem_sh, mem_sb, mem_swl, mem_swr});

endmodule

/* verilog/exe_stage.sv */
`include "exe_settings.svh"

module exe_stage
    import exe_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,

    // from decode
    input  logic                       in_valid,
    output logic                       in_ready,
    input  alu_op_t                    in_alu_op,
    input  src1_sel_t                  in_src1_sel,
    input  src2_sel_t                  in_src2_sel,
    input  mem_op_t                    in_mem_op,
    input  logic [`EXE_IMM_W-1:0]      in_imm,
    input  logic [`EXE_DATA_W-1:0]     in_rs_value,
    input  logic [`EXE_DATA_W-1:0]     in_rt_value,
    input  logic [`EXE_DATA_W-1:0]     in_pc,
    input  logic [`EXE_REG_ADDR_W-1:0] in_dest,
    input  logic                       in_gr_we,
    input  logic                       in_ov_check,

    // to memory stage
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`EXE_DATA_W-1:0]     out_result,
    output logic [`EXE_REG_ADDR_W-1:0] out_dest,
    output logic                       out_gr_we,
    output mem_op_t                    out_mem_op,
    output logic                       out_ex,
    output exc_code_t                  out_excode,

    // data memory request
    output logic                       mem_req,
    output logic                       mem_wr,
    output logic [`EXE_SIZE_W-1:0]     mem_size,
    output logic [`EXE_DATA_W-1:0]     mem_addr,
    output logic [`EXE_STRB_W-1:0]     mem_wstrb,
    output logic [`EXE_DATA_W-1:0]     mem_wdata,
    input  logic                       mem_addr_ok
);

    exe_op_if op ();

    exe_control u_control (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_alu_op   (in_alu_op),
        .in_src1_sel (in_src1_sel),
        .in_src2_sel (in_src2_sel),
        .in_mem_op   (in_mem_op),
        .in_imm      (in_imm),
        .in_rs_value (in_rs_value),
        .in_rt_value (in_rt_value),
        .in_pc       (in_pc),
        .in_dest     (in_dest),
        .in_gr_we    (in_gr_we),
        .in_ov_check (in_ov_check),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_dest    (out_dest),
        .out_gr_we   (out_gr_we),
        .out_mem_op  (out_mem_op),
        .out_ex      (out_ex),
        .out_excode  (out_excode),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_addr_ok (mem_addr_ok),
        .op          (op.ctrl)
    );

    exe_alu u_alu (
        .op         (op.alu),
        .out_result (out_result)
    );

    exe_hilo u_hilo (
        .clk   (clk),
        .reset (reset),
        .op    (op.hilo)
    );

    exe_store_format u_store_format (
        .op        (op.store),
        .mem_wr    (mem_wr),
        .mem_size  (mem_size),
        .mem_wstrb (mem_wstrb),
        .mem_wdata (mem_wdata)
    );

endmodule

/* bench/exe_stage_tb.sv */
`include "exe_settings.svh"

module exe_stage_tb
    import exe_pkg::*;
();

    localparam int NUM_INSTR  = 400;
    // a few cycles per instruction at 70 percent ready plus a wide margin
    localparam int MAX_CYCLES = NUM_INSTR * 20;

    typedef struct packed {
        alu_op_t                    alu_op;
        mem_op_t                    mem_op;
        logic [`EXE_DATA_W-1:0]     a;
        logic [`EXE_DATA_W-1:0]     b;
        logic [`EXE_DATA_W-1:0]     result;
        logic [`EXE_DATA_W-1:0]     wdata;
        logic [`EXE_STRB_W-1:0]     strb;
        logic [`EXE_SIZE_W-1:0]     size;
        logic [`EXE_REG_ADDR_W-1:0] dest;
        logic                       gr_we;
        logic                       is_store;
        logic                       ex;
        exc_code_t                  excode;
    } expected_t;

    logic                       clk;
    logic                       reset;
    logic                       flush;
    logic                       in_valid;
    logic                       in_ready;
    alu_op_t                    in_alu_op;
    src1_sel_t                  in_src1_sel;
    src2_sel_t                  in_src2_sel;
    mem_op_t                    in_mem_op;
    logic [`EXE_IMM_W-1:0]      in_imm;
    logic [`EXE_DATA_W-1:0]     in_rs_value;
    logic [`EXE_DATA_W-1:0]     in_rt_value;
    logic [`EXE_DATA_W-1:0]     in_pc;
    logic [`EXE_REG_ADDR_W-1:0] in_dest;
    logic                       in_gr_we;
    logic                       in_ov_check;
    logic                       out_valid;
    logic                       out_ready;
    logic [`EXE_DATA_W-1:0]     out_result;
    logic [`EXE_REG_ADDR_W-1:0] out_dest;
    logic                       out_gr_we;
    mem_op_t                    out_mem_op;
    logic                       out_ex;
    exc_code_t                  out_excode;
    logic                       mem_req;
    logic                       mem_wr;
    logic [`EXE_SIZE_W-1:0]     mem_size;
    logic [`EXE_DATA_W-1:0]     mem_addr;
    logic [`EXE_STRB_W-1:0]     mem_wstrb;
    logic [`EXE_DATA_W-1:0]     mem_wdata;
    logic                       mem_addr_ok;

    // reference model state
    logic [31:0]            rng_state;
    logic [`EXE_DATA_W-1:0] hi_m;
    logic [`EXE_DATA_W-1:0] lo_m;
    expected_t              pending[$];
    expected_t              cur;
    logic                   held;
    logic                   req_taken;
    logic                   consumed;
    int                     issued;
    int                     cycles;

    logic go_m;
    logic want_valid;
    logic want_in_ready;
    logic want_req;

    exe_stage uut (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_alu_op   (in_alu_op),
        .in_src1_sel (in_src1_sel),
        .in_src2_sel (in_src2_sel),
        .in_mem_op   (in_mem_op),
        .in_imm      (in_imm),
        .in_rs_value (in_rs_value),
        .in_rt_value (in_rt_value),
        .in_pc       (in_pc),
        .in_dest     (in_dest),
        .in_gr_we    (in_gr_we),
        .in_ov_check (in_ov_check),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result),
        .out_dest    (out_dest),
        .out_gr_we   (out_gr_we),
        .out_mem_op  (out_mem_op),
        .out_ex      (out_ex),
        .out_excode  (out_excode),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_size    (mem_size),
        .mem_addr    (mem_addr),
        .mem_wstrb   (mem_wstrb),
        .mem_wdata   (mem_wdata),
        .mem_addr_ok (mem_addr_ok)
    );

    // expected handshake from the held model entry
    assign go_m          = cur.mem_op == mem_none || cur.ex || req_taken || mem_addr_ok;
    assign want_valid    = held && !flush && go_m;
    assign want_in_ready = !held || (go_m && out_ready);
    assign want_req      = held && !flush && cur.mem_op != mem_none && !cur.ex && !req_taken;

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic flag_wrong_value(input string name, input logic [31:0] got,
                                    input logic [31:0] want);
        fail_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                           $time, name, got, want));
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic chance(input int pct);
        return (next_rand() % 100) < pct;
    endfunction

    // strobe tables hold four 4-bit entries, offset 0 in the low nibble
    function automatic logic [3:0] from_table(input logic [15:0] tab, input logic [1:0] offs);
        return tab[offs*4 +: 4];
    endfunction

    function automatic expected_t predict();
        expected_t              e;
        logic [`EXE_DATA_W-1:0] sum;
        logic [1:0]             offs;
        logic                   ov;
        logic                   adel;
        logic                   ades;
        e.alu_op = in_alu_op;
        e.mem_op = in_mem_op;
        e.dest   = in_dest;
        e.gr_we  = in_gr_we;
        case (in_src1_sel)
            src1_pc: e.a = in_pc;
            src1_sa: e.a = 32'(in_imm[10:6]);
            default: e.a = in_rs_value;
        endcase
        case (in_src2_sel)
            src2_simm: e.b = 32'($signed(in_imm));
            src2_zimm: e.b = 32'(in_imm);
            src2_link: e.b = `EXE_LINK_OFFSET;
            default:   e.b = in_rt_value;
        endcase
        if (in_alu_op == alu_sub) begin
            sum = e.a - e.b;
            ov  = (e.a[31] != e.b[31]) && (sum[31] != e.a[31]);
        end else begin
            sum = e.a + e.b;
            ov  = (in_alu_op == alu_add) && (e.a[31] == e.b[31]) && (sum[31] != e.a[31]);
        end
        case (in_alu_op)
            alu_add, alu_sub: e.result = sum;
            alu_slt:  e.result = 32'($signed(e.a) < $signed(e.b));
            alu_sltu: e.result = 32'(e.a < e.b);
            alu_and:  e.result = e.a & e.b;
            alu_or:   e.result = e.a | e.b;
            alu_xor:  e.result = e.a ^ e.b;
            alu_nor:  e.result = ~(e.a | e.b);
            alu_sll:  e.result = e.b << e.a[4:0];
            alu_srl:  e.result = e.b >> e.a[4:0];
            alu_sra:  e.result = $signed(e.b) >>> e.a[4:0];
            alu_lui:  e.result = {in_imm, 16'h0000};
            alu_mfhi: e.result = hi_m;
            alu_mflo: e.result = lo_m;
            default:  e.result = e.a;
        endcase
        offs = e.result[1:0];
        adel = (in_mem_op == mem_lw && offs != 2'b00) ||
               ((in_mem_op == mem_lh || in_mem_op == mem_lhu) && offs[0]);
        ades = (in_mem_op == mem_sw && offs != 2'b00) || (in_mem_op == mem_sh && offs[0]);
        // ov first, then adel, then ades
        if (in_ov_check && ov) begin
            e.excode = exc_ov;
        end else if (adel) begin
            e.excode = exc_adel;
        end else if (ades) begin
            e.excode = exc_ades;
        end else begin
            e.excode = exc_none;
        end
        e.ex = (e.excode != exc_none);
        e.is_store = in_mem_op inside {mem_sw, mem_sh, mem_sb, mem_swl, mem_swr};
        e.wdata    = in_rt_value;
        e.strb     = 4'h0;
        case (in_mem_op)
            mem_sw:  e.strb = 4'hf;
            mem_sb:  e.strb = from_table(16'h8421, offs);
            mem_sh:  e.strb = from_table(16'h0c03, offs);
            mem_swl: e.strb = from_table(16'hf731, offs);
            mem_swr: e.strb = from_table(16'h8cef, offs);
            default: e.strb = 4'h0;
        endcase
        case (in_mem_op)
            mem_sb:  e.wdata = {4{in_rt_value[7:0]}};
            mem_sh:  e.wdata = {2{in_rt_value[15:0]}};
            mem_swl: e.wdata = in_rt_value >> (24 - 8 * offs);
            mem_swr: e.wdata = in_rt_value << (8 * offs);
            default: e.wdata = in_rt_value;
        endcase
        case (in_mem_op)
            mem_lb, mem_lbu, mem_sb: e.size = 3'd0;
            mem_lh, mem_lhu, mem_sh: e.size = 3'd1;
            default:                 e.size = 3'd2;
        endcase
        return e;
    endfunction

    task automatic apply_hilo(input expected_t e);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic        [63:0] prod;
        sa = $signed(e.a);
        sb = $signed(e.b);
        case (e.alu_op)
            alu_mult: begin
                prod = sa * sb;
                hi_m = prod[63:32];
                lo_m = prod[31:0];
            end
            alu_multu: begin
                prod = {32'h0, e.a} * {32'h0, e.b};
                hi_m = prod[63:32];
                lo_m = prod[31:0];
            end
            alu_mthi: hi_m = e.a;
            alu_mtlo: lo_m = e.a;
            default: begin
            end
        endcase
    endtask

    task automatic offer_random();
        logic [31:0] r;
        r = next_rand();
        in_valid    = 1'b1;
        in_mem_op   = r[4] ? mem_none : mem_op_t'(r[3:0] % 4'd11);
        in_alu_op   = alu_op_t'(r[12:8] % 5'd18);
        // extra weight on hi/lo traffic
        if (r[6:5] == 2'b00) begin
            in_alu_op = alu_op_t'(5'd12 + r[10:8] % 3'd6);
        end
        in_src1_sel = src1_sel_t'(r[14:13] % 2'd3);
        in_src2_sel = src2_sel_t'(r[16:15]);
        if (in_mem_op != mem_none) begin
            in_alu_op   = alu_add;
            in_src1_sel = src1_rs;
            in_src2_sel = src2_simm;
        end
        in_ov_check = r[17];
        in_gr_we    = r[18];
        in_dest     = r[23:19];
        in_imm      = 16'(next_rand());
        in_rs_value = next_rand();
        in_rt_value = next_rand();
        in_pc       = next_rand();
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == MAX_CYCLES) begin
            fail_run("timeout, the run did not finish within the cycle limit");
        end
    end

    // model bookkeeping on its own predictions
    always @(posedge clk) begin
        expected_t done;
        consumed = in_valid && want_in_ready;
        if (reset) begin
            pending.delete();
            hi_m      = '0;
            lo_m      = '0;
            req_taken = 1'b0;
        end else if (flush) begin
            if (held) begin
                void'(pending.pop_front());
            end
            req_taken = 1'b0;
        end else begin
            if (want_req && mem_addr_ok) begin
                req_taken = 1'b1;
            end
            if (want_valid && out_ready) begin
                done = pending.pop_front();
                if (!done.ex) begin
                    apply_hilo(done);
                end
                req_taken = 1'b0;
            end
            if (consumed) begin
                pending.push_back(predict());
            end
        end
        if (consumed) begin
            issued++;
        end
        held = (pending.size() != 0);
        if (held) begin
            cur = pending[0];
        end
    end

    assert property (@(posedge clk) disable iff (reset) out_valid == want_valid)
        else flag_wrong_value("out_valid", $sampled(out_valid), $sampled(want_valid));
    assert property (@(posedge clk) disable iff (reset) in_ready == want_in_ready)
        else flag_wrong_value("in_ready", $sampled(in_ready), $sampled(want_in_ready));
    assert property (@(posedge clk) disable iff (reset) mem_req == want_req)
        else flag_wrong_value("mem_req", $sampled(mem_req), $sampled(want_req));
    assert property (@(posedge clk) disable iff (reset) out_valid |-> out_ex == cur.ex)
        else flag_wrong_value("out_ex", $sampled(out_ex), $sampled(cur.ex));
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !cur.ex |-> out_result == cur.result)
        else flag_wrong_value("out_result", $sampled(out_result), $sampled(cur.result));
    assert property (@(posedge clk) disable iff (reset) out_valid |-> out_dest == cur.dest)
        else flag_wrong_value("out_dest", $sampled(out_dest), $sampled(cur.dest));
    assert property (@(posedge clk) disable iff (reset) out_valid |-> out_gr_we == cur.gr_we)
        else flag_wrong_value("out_gr_we", $sampled(out_gr_we), $sampled(cur.gr_we));
    assert property (@(posedge clk) disable iff (reset) out_valid |-> out_mem_op == cur.mem_op)
        else flag_wrong_value("out_mem_op", $sampled(out_mem_op), $sampled(cur.mem_op));
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_excode == cur.excode)
        else flag_wrong_value("out_excode", $sampled(out_excode), $sampled(cur.excode));
    assert property (@(posedge clk) disable iff (reset) mem_req |-> mem_addr == cur.result)
        else flag_wrong_value("mem_addr", $sampled(mem_addr), $sampled(cur.result));
    assert property (@(posedge clk) disable iff (reset) mem_req |-> mem_wdata == cur.wdata)
        else flag_wrong_value("mem_wdata", $sampled(mem_wdata), $sampled(cur.wdata));
    assert property (@(posedge clk) disable iff (reset) mem_req |-> mem_wstrb == cur.strb)
        else flag_wrong_value("mem_wstrb", $sampled(mem_wstrb), $sampled(cur.strb));
    assert property (@(posedge clk) disable iff (reset) mem_req |-> mem_size == cur.size)
        else flag_wrong_value("mem_size", $sampled(mem_size), $sampled(cur.size));
    assert property (@(posedge clk) disable iff (reset) mem_req |-> mem_wr == cur.is_store)
        else flag_wrong_value("mem_wr", $sampled(mem_wr), $sampled(cur.is_store));
    assert property (@(posedge clk) disable iff (reset) !mem_req |-> mem_wstrb == '0)
        else flag_wrong_value("mem_wstrb", $sampled(mem_wstrb), 32'h0);
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> flush || (out_valid && $stable(out_result) &&
            $stable(out_dest) && $stable(out_gr_we) && $stable(out_mem_op) &&
            $stable(out_ex) && $stable(out_excode) && $stable(mem_addr) &&
            $stable(mem_wdata) && $stable(mem_size) && $stable(mem_wr)))
        else fail_run("outputs changed while the stage was stalled");
    assert property (@(posedge clk) $fell(reset) |-> !out_valid && !mem_req && in_ready)
        else fail_run("stage was not idle in the cycle after reset");

    initial begin
        rng_state   = 32'd59123;
        cycles      = 0;
        issued      = 0;
        held        = 1'b0;
        req_taken   = 1'b0;
        consumed    = 1'b0;
        reset       = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_alu_op   = alu_add;
        in_src1_sel = src1_rs;
        in_src2_sel = src2_rt;
        in_mem_op   = mem_none;
        in_imm      = '0;
        in_rs_value = '0;
        in_rt_value = '0;
        in_pc       = '0;
        in_dest     = '0;
        in_gr_we    = 1'b0;
        in_ov_check = 1'b0;
        out_ready   = 1'b0;
        mem_addr_ok = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (issued < NUM_INSTR) begin
            @(negedge clk);
            // hold an offer until the stage takes it
            if (!in_valid || consumed) begin
                if (issued < NUM_INSTR && chance(80)) begin
                    offer_random();
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready   = chance(70);
            mem_addr_ok = chance(70);
            flush       = chance(4);
        end
        in_valid    = 1'b0;
        flush       = 1'b0;
        out_ready   = 1'b1;
        mem_addr_ok = 1'b1;
        while (held) begin
            @(negedge clk);
        end
        @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* project.f */
+incdir+verilog
verilog/exe_pkg.sv
verilog/exe_op_if.sv
verilog/exe_control.sv
verilog/exe_alu.sv
verilog/exe_hilo.sv
verilog/exe_store_format.sv
verilog/exe_stage.sv
bench/exe_stage_tb.sv

/* Bender.yml */
package:
  name: exe_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exe_pkg.sv
      - verilog/exe_op_if.sv
      - verilog/exe_control.sv
      - verilog/exe_alu.sv
      - verilog/exe_hilo.sv
      - verilog/exe_store_format.sv
      - verilog/exe_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/exe_stage_tb.sv
